//--- Bender.yml
package:
  name: instruction_decode

sources:
  # Decode stage RTL, package first
  - target: any(rtl, test)
    files:
      - hdl/decodePkg.sv
      - hdl/mainControl.sv
      - hdl/registerFile.sv
      - hdl/branchResolve.sv
      - hdl/hazardUnit.sv
      - hdl/instructionDecode.sv

  # Testbench, top module tbInstructionDecode
  - target: test
    files:
      - bench/decodeChecker.sv
      - bench/tbInstructionDecode.sv

//--- bench/decodeChecker.sv
module decodeChecker import decodePkg::*; (
  input  logic        Clock,
  input  logic        checkEn,
  input  logic [31:0] instruction,
  input  logic [31:0] pcPlusFour,
  input  logic [4:0]  rtEx,
  input  logic [4:0]  rdEx,
  input  logic [4:0]  rDestSelectedMem,
  input  logic [5:0]  opcodeEx,
  input  logic [5:0]  opcodeMem,
  input  logic        pcSel,
  input  logic [31:0] branchPc,
  input  logic        regWriteOut,
  input  logic        memToReg,
  input  logic        rEnable,
  input  logic        wEnable,
  input  logic [1:0]  rWidth,
  input  logic [1:0]  wWidth,
  input  logic        regDst,
  input  logic [1:0]  aluSrc1,
  input  logic        aluSrc0,
  input  logic [31:0] regData1,
  input  logic [31:0] regData2,
  input  logic [31:0] imm32,
  input  logic        stallPc,
  input  logic        stallId,
  input  logic        stallIdEx,
  output int          checkCount,
  output int          errorCount
);

  task automatic compareValue(input string name, input logic [31:0] expV,
                              input logic [31:0] actV);
    if (actV !== expV) begin
      errorCount++;
      $display("mismatch %s at %0t: expected 0x%h, actual 0x%h", name, $time, expV, actV);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model of one decode cycle
  //////////////////////////////////////////////////

  task automatic checkRow();
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [4:0]  exDest;
    logic [31:0] d1;
    logic [31:0] d2;
    logic [31:0] imm;
    logic [31:0] expPc;
    logic        expSel;
    logic        isLoad;
    logic        isAlu;
    logic        usesRs;
    logic        usesRt;
    logic        hazard;
    op = instruction[31:26];
    fn = instruction[5:0];
    isLoad = (op == Lw) || (op == Lb);
    isAlu = (op == RType) && (fn inside {Add, Sub, And, Or, Slt});

    // jal reads r31 on rs and both j and jal read r0 on rt
    rsAddr = (op == Jal) ? 5'd31 : instruction[25:21];
    rtAddr = ((op == J) || (op == Jal)) ? 5'd0 : instruction[20:16];
    d1 = tbInstructionDecode.shadowRegs[rsAddr];
    d2 = tbInstructionDecode.shadowRegs[rtAddr];
    imm = 32'($signed(instruction[15:0]));

    // Redirect with the branch target as the fallback address
    expSel = 1'b0;
    expPc = pcPlusFour + imm * 4;
    if (op == Beq) begin
      expSel = (d1 == d2);
    end else if (op == Bne) begin
      expSel = (d1 != d2);
    end else if ((op == J) || (op == Jal)) begin
      expSel = 1'b1;
      expPc = (pcPlusFour & 32'hf000_0000) | (32'(instruction[25:0]) << 2);
    end else if ((op == RType) && (fn == Jr)) begin
      expSel = 1'b1;
      expPc = d1;
    end

    // Stalls from EX and MEM producers
    exDest = (opcodeEx == RType) ? rdEx : rtEx;
    usesRs = (op == Beq) || (op == Bne) || ((op == RType) && (fn == Jr));
    usesRt = (op == Beq) || (op == Bne);
    hazard = (opcodeEx inside {Lw, Lb}) && (exDest != 0)
             && ((exDest == instruction[25:21]) || (exDest == instruction[20:16]));
    if ((opcodeEx inside {RType, Addi, Lw, Lb}) && (exDest != 0)
        && ((usesRs && exDest == instruction[25:21]) || (usesRt && exDest == instruction[20:16])))
      hazard = 1'b1;
    if ((opcodeMem inside {Lw, Lb}) && (rDestSelectedMem != 0)
        && ((usesRs && rDestSelectedMem == instruction[25:21])
            || (usesRt && rDestSelectedMem == instruction[20:16])))
      hazard = 1'b1;

    compareValue("regDst", isAlu, regDst);
    compareValue("aluSrc0", 0, aluSrc0);
    compareValue("aluSrc1", (op == Addi || isLoad) ? 1 : ((op == Jal) ? 2 : 0), aluSrc1);
    compareValue("rEnable", isLoad, rEnable);
    compareValue("wEnable", (op == Sw) || (op == Sb), wEnable);
    compareValue("rWidth", (op == Lw) ? 2 : 0, rWidth);
    compareValue("wWidth", (op == Sw) ? 2 : 0, wWidth);
    compareValue("memToReg", isLoad, memToReg);
    compareValue("regWriteOut", isAlu || isLoad || op == Addi || op == Jal, regWriteOut);
    compareValue("regData1", d1, regData1);
    compareValue("regData2", d2, regData2);
    compareValue("imm32", imm, imm32);
    compareValue("pcSel", expSel, pcSel);
    compareValue("branchPc", expPc, branchPc);
    compareValue("stallPc", hazard, stallPc);
    compareValue("stallId", hazard, stallId);
    compareValue("stallIdEx", hazard, stallIdEx);
    checkCount++;
  endtask

  // Sample 2 units before the next rising edge
  initial begin
    errorCount = 0;
    checkCount = 0;
    forever begin
      @(posedge Clock);
      #8;
      if (checkEn) begin
        checkRow();
      end
    end
  end

endmodule

//--- bench/tbInstructionDecode.sv
module tbInstructionDecode import decodePkg::*; ();

  logic        Clock;
  logic        rstN;
  logic [31:0] instruction;
  logic [31:0] pcPlusFour;
  logic [4:0]  rDestSelectedId;
  logic [31:0] regWriteData;
  logic        regWrite;
  logic [4:0]  rtEx;
  logic [4:0]  rdEx;
  logic [4:0]  rDestSelectedMem;
  logic [5:0]  opcodeEx;
  logic [5:0]  opcodeMem;
  logic        pcSel;
  logic [31:0] branchPc;
  logic        regWriteOut;
  logic        memToReg;
  logic        rEnable;
  logic        wEnable;
  logic [1:0]  rWidth;
  logic [1:0]  wWidth;
  logic        regDst;
  logic [1:0]  aluSrc1;
  logic        aluSrc0;
  logic [31:0] regData1;
  logic [31:0] regData2;
  logic [31:0] imm32;
  logic        stallPc;
  logic        stallId;
  logic        stallIdEx;
  logic        checkEn;
  int          checkCount;
  int          errorCount;
  int          cycleCount;
  int          cycleLimit;

  // Register file mirror read by the checker
  logic [31:0] shadowRegs [0:31];
  logic [31:0] preloadVals [1:8];

  // One decode cycle with its EX/MEM context and an optional write
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc4;
    logic [5:0]  opEx;
    logic [4:0]  exRt;
    logic [4:0]  exRd;
    logic [5:0]  opMem;
    logic [4:0]  memDest;
    logic        wEn;
    logic [4:0]  wAddr;
    logic [31:0] wData;
  } rowT;

  rowT rows[$];
  rowT cur;

  instructionDecode u_instructionDecode (.*);
  decodeChecker u_decodeChecker (.*);

  initial begin
    Clock = 1'b0;
    forever #5 Clock = ~Clock;
  end

  // Write lands at the edge just like in the register file
  always @(posedge Clock) begin
    if (regWrite && (rDestSelectedId != 5'd0))
      shadowRegs[rDestSelectedId] <= regWriteData;
  end

  //////////////////////////////////////////////////
  // Encoders and table rows
  //////////////////////////////////////////////////

  function automatic logic [31:0] rFormat(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
    return {6'd0, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jFormat(input logic [5:0] op, input logic [25:0] index);
    return {op, index};
  endfunction

  task automatic decodeRow(input logic [31:0] instr, pc4, input logic [5:0] opEx,
                           input logic [4:0] exRt, exRd, input logic [5:0] opMem,
                           input logic [4:0] memDest);
    rows.push_back({instr, pc4, opEx, exRt, exRd, opMem, memDest, 1'b0, 5'd0, 32'd0});
  endtask

  // Reads the target register in the same cycle, so no write-through shows
  task automatic writeRow(input logic [4:0] addr, input logic [31:0] data);
    rows.push_back({rFormat(addr, addr, 5'd0, Or), 32'h0040_0080, 6'd0, 5'd0, 5'd0, 6'd0,
                    5'd0, 1'b1, addr, data});
  endtask

  task automatic buildTable();
    // Control decode of the subset with a nop first
    decodeRow(32'd0, 32'h0040_0004, RType, 0, 0, RType, 0);
    decodeRow(rFormat(1, 2, 3, Add), 32'h0040_0008, RType, 0, 0, RType, 0);
    decodeRow(rFormat(4, 5, 6, Sub), 32'h0040_000c, RType, 0, 0, RType, 0);
    decodeRow(rFormat(7, 8, 1, And), 32'h0040_0010, RType, 0, 0, RType, 0);
    decodeRow(rFormat(2, 3, 4, Or), 32'h0040_0014, RType, 0, 0, RType, 0);
    decodeRow(rFormat(5, 6, 7, Slt), 32'h0040_0018, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Addi, 1, 9, 16'h0010), 32'h0040_001c, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Addi, 2, 10, 16'hfff0), 32'h0040_0020, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Lw, 3, 11, 16'h0008), 32'h0040_0024, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Lb, 4, 12, 16'hfffc), 32'h0040_0028, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Sw, 6, 5, 16'h000c), 32'h0040_002c, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Sb, 8, 7, 16'h8001), 32'h0040_0030, RType, 0, 0, RType, 0);
    // Branches on preloaded values
    decodeRow(iFormat(Beq, 1, 1, 16'h0003), 32'h0040_0100, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Beq, 1, 2, 16'hfffe), 32'h0040_0104, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Bne, 1, 2, 16'h0005), 32'h0040_0108, RType, 0, 0, RType, 0);
    decodeRow(iFormat(Bne, 4, 4, 16'h7fff), 32'h0040_010c, RType, 0, 0, RType, 0);
    // Jumps
    decodeRow(jFormat(J, 26'h012_3456), 32'h8000_0010, RType, 0, 0, RType, 0);
    decodeRow(jFormat(Jal, 26'h3ff_ffff), 32'h1000_0004, RType, 0, 0, RType, 0);
    decodeRow(rFormat(5, 0, 0, Jr), 32'h0040_0110, RType, 0, 0, RType, 0);
    // Write then read back with r0 staying zero and jal reading r31
    writeRow(9, preloadVals[3]);
    decodeRow(iFormat(Beq, 3, 9, 16'h0004), 32'h0040_0114, RType, 0, 0, RType, 0);
    writeRow(0, 32'hdead_beef);
    decodeRow(rFormat(0, 0, 1, Add), 32'h0040_0118, RType, 0, 0, RType, 0);
    writeRow(31, 32'h0040_0100);
    decodeRow(jFormat(Jal, 26'h000_0040), 32'h0040_0200, RType, 0, 0, RType, 0);
    decodeRow(rFormat(31, 0, 0, Jr), 32'h0040_0204, RType, 0, 0, RType, 0);
    // Load-use and branch operand hazards
    decodeRow(rFormat(1, 2, 3, Add), 32'h0040_0300, Lw, 1, 0, RType, 0);
    decodeRow(rFormat(1, 2, 3, Add), 32'h0040_0300, Lb, 2, 0, RType, 0);
    decodeRow(rFormat(0, 4, 3, Add), 32'h0040_0300, Lw, 0, 0, RType, 0);
    decodeRow(rFormat(1, 2, 3, Add), 32'h0040_0300, Lw, 5, 0, RType, 0);
    decodeRow(rFormat(1, 2, 3, Add), 32'h0040_0300, RType, 7, 1, RType, 0);
    decodeRow(iFormat(Beq, 1, 2, 16'h0002), 32'h0040_0300, RType, 7, 2, RType, 0);
    decodeRow(iFormat(Beq, 4, 5, 16'h0002), 32'h0040_0300, Addi, 4, 0, RType, 0);
    decodeRow(iFormat(Bne, 6, 7, 16'h0002), 32'h0040_0300, RType, 0, 0, Lw, 7);
    decodeRow(iFormat(Bne, 6, 7, 16'h0002), 32'h0040_0300, RType, 0, 0, RType, 7);
    decodeRow(iFormat(Beq, 1, 2, 16'h0002), 32'h0040_0300, RType, 2, 3, RType, 0);
    decodeRow(rFormat(5, 0, 0, Jr), 32'h0040_0300, RType, 0, 0, Lb, 5);
  endtask

  //////////////////////////////////////////////////
  // Reset, preload and table loop
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(98));
    rstN = 1'b0;
    instruction = '0;
    pcPlusFour = '0;
    rDestSelectedId = '0;
    regWriteData = '0;
    regWrite = 1'b0;
    rtEx = '0;
    rdEx = '0;
    rDestSelectedMem = '0;
    opcodeEx = '0;
    opcodeMem = '0;
    checkEn = 1'b0;
    for (int i = 0; i < 32; i++) begin
      shadowRegs[i] = '0;
    end
    for (int i = 1; i <= 8; i++) begin
      preloadVals[i] = $urandom();
    end
    buildTable();
    // Reset and preload cycles plus one per row and a margin
    cycleLimit = 3 + 8 + rows.size() + 20;

    repeat (3) @(posedge Clock);
    #1 rstN = 1'b1;
    for (int i = 1; i <= 8; i++) begin
      @(posedge Clock);
      #1;
      regWrite = 1'b1;
      rDestSelectedId = 5'(i);
      regWriteData = preloadVals[i];
    end

    foreach (rows[i]) begin
      @(posedge Clock);
      #1;
      cur = rows[i];
      instruction = cur.instr;
      pcPlusFour = cur.pc4;
      opcodeEx = cur.opEx;
      rtEx = cur.exRt;
      rdEx = cur.exRd;
      opcodeMem = cur.opMem;
      rDestSelectedMem = cur.memDest;
      regWrite = cur.wEn;
      rDestSelectedId = cur.wAddr;
      regWriteData = cur.wData;
      checkEn = 1'b1;
    end

    @(posedge Clock);
    #1;
    checkEn = 1'b0;
    regWrite = 1'b0;
    @(posedge Clock);

    $display("Checked %0d of %0d rows, %0d mismatches", checkCount, rows.size(), errorCount);
    if (checkCount != rows.size())
      $display("Not every table row reached the checker");
    if ((errorCount == 0) && (checkCount == rows.size())) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Run stops at the cycle limit
  initial begin
    cycleCount = 0;
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge Clock);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- build.f
hdl/decodePkg.sv
hdl/mainControl.sv
hdl/registerFile.sv
hdl/branchResolve.sv
hdl/hazardUnit.sv
hdl/instructionDecode.sv
bench/decodeChecker.sv
bench/tbInstructionDecode.sv

//--- hdl/branchResolve.sv
module branchResolve import decodePkg::*; (
  input  logic [DataW-1:0] instr,
  input  logic [DataW-1:0] pcPlusFour,
  input  logic [DataW-1:0] rsData,
  input  logic [DataW-1:0] rtData,
  output logic [DataW-1:0] imm32,
  output logic             pcSel,
  output logic [DataW-1:0] branchPc
);

  opcodeT           opcode;
  functT            funct;
  logic [DataW-1:0] branchTarget;
  logic [DataW-1:0] jumpTarget;
  logic             operandsEqual;

  assign opcode = opcodeT'(instr[31:26]);
  assign funct  = functT'(instr[5:0]);

  //////////////////////////////////////////////////
  // Immediate and target arithmetic
  //////////////////////////////////////////////////

  // Sign extension of the 16-bit offset
  assign imm32 = {{16{instr[15]}}, instr[15:0]};

  // Word offset relative to the delay PC
  assign branchTarget = pcPlusFour + (imm32 << 2);

  // Pseudo-direct target inside the current 256 MB region
  assign jumpTarget = {pcPlusFour[31:28], instr[25:0], 2'b00};

  // Early compare for beq and bne
  assign operandsEqual = (rsData == rtData);

  //////////////////////////////////////////////////
  // Redirect decision
  //////////////////////////////////////////////////

  always_comb begin
    pcSel    = 1'b0;
    branchPc = branchTarget;

    case (opcode)
      Beq: pcSel = operandsEqual;
      Bne: pcSel = !operandsEqual;
      J, Jal: begin
        pcSel    = 1'b1;
        branchPc = jumpTarget;
      end
      RType: begin
        // jr jumps to the register value
        if (funct == Jr) begin
          pcSel    = 1'b1;
          branchPc = rsData;
        end
      end
      default: begin
      end
    endcase
  end

  // Fetch may only be redirected by control transfer instructions
  redirectOnlyOnBranch: assert final (
    !pcSel || (opcode inside {Beq, Bne, J, Jal}) || ((opcode == RType) && (funct == Jr))
  ) else $error("branchResolve: pcSel high for opcode %h", opcode);

endmodule

//--- hdl/decodePkg.sv
package decodePkg;

  //////////////////////////////////////////////////
  // Widths and fixed register numbers
  //////////////////////////////////////////////////

  localparam int RegAddrW = 5;
  localparam int DataW    = 32;

  // Destination of the jal link write
  localparam logic [RegAddrW-1:0] LinkReg = 5'd31;

  // Memory access size codes
  localparam logic [1:0] WidthByte = 2'd0;
  localparam logic [1:0] WidthWord = 2'd2;

  // ALU operand B sources
  localparam logic [1:0] AluSrcReg  = 2'd0;
  localparam logic [1:0] AluSrcImm  = 2'd1;
  localparam logic [1:0] AluSrcLink = 2'd2;

  //////////////////////////////////////////////////
  // Instruction encodings of the supported subset
  //////////////////////////////////////////////////

  typedef enum logic [5:0] {
    RType = 6'd0,
    J     = 6'd2,
    Jal   = 6'd3,
    Beq   = 6'd4,
    Bne   = 6'd5,
    Addi  = 6'd8,
    Lb    = 6'd32,
    Lw    = 6'd35,
    Sb    = 6'd40,
    Sw    = 6'd43
  } opcodeT;

  // R-type function field
  typedef enum logic [5:0] {
    Jr  = 6'd8,
    Add = 6'd32,
    Sub = 6'd34,
    And = 6'd36,
    Or  = 6'd37,
    Slt = 6'd42
  } functT;

  // Control bundle handed on to EX, MEM and WB
  typedef struct packed {
    logic       regDst;
    // Shift amount select, no user in this subset
    logic       aluSrc0;
    logic [1:0] aluSrc1;
    logic       rEnable;
    logic       wEnable;
    logic [1:0] rWidth;
    logic [1:0] wWidth;
    logic       memToReg;
    logic       regWrite;
  } ctrlT;

endpackage

// Two read ports of the register file
interface regReadIf import decodePkg::*; ();
  logic [RegAddrW-1:0] rsAddr;
  logic [RegAddrW-1:0] rtAddr;
  logic [DataW-1:0]    rsData;
  logic [DataW-1:0]    rtData;

  modport requester (output rsAddr, rtAddr, input rsData, rtData);
  modport responder (input rsAddr, rtAddr, output rsData, rtData);
endinterface

//--- hdl/hazardUnit.sv
module hazardUnit import decodePkg::*; (
  input  opcodeT              opcodeId,
  input  functT               functId,
  input  logic [RegAddrW-1:0] rsId,
  input  logic [RegAddrW-1:0] rtId,
  input  opcodeT              opcodeEx,
  input  logic [RegAddrW-1:0] rtEx,
  input  logic [RegAddrW-1:0] rdEx,
  input  opcodeT              opcodeMem,
  input  logic [RegAddrW-1:0] rDestMem,
  output logic                stallPc,
  output logic                stallId,
  output logic                stallIdEx
);

  logic [RegAddrW-1:0] exDest;
  logic                exLoad;
  logic                exWrites;
  logic                memLoad;
  logic                usesRs;
  logic                usesRt;
  logic                loadUse;
  logic                branchHazard;
  logic                hazard;

  //////////////////////////////////////////////////
  // Producer side in EX and MEM
  //////////////////////////////////////////////////

  // R-type writes rd, I-type writes rt
  assign exDest   = (opcodeEx == RType) ? rdEx : rtEx;
  assign exLoad   = opcodeEx inside {Lw, Lb};
  assign exWrites = opcodeEx inside {RType, Addi, Lw, Lb};
  assign memLoad  = opcodeMem inside {Lw, Lb};

  //////////////////////////////////////////////////
  // Consumer side in ID
  //////////////////////////////////////////////////

  // Branch operands read in ID, jr needs rs only
  assign usesRs = (opcodeId inside {Beq, Bne}) || ((opcodeId == RType) && (functId == Jr));
  assign usesRt = opcodeId inside {Beq, Bne};

  // Load result not ready for the next instruction
  assign loadUse = exLoad && (exDest != '0) && ((exDest == rsId) || (exDest == rtId));

  // Compare in ID needs the value before EX or MEM has it
  always_comb begin
    branchHazard = 1'b0;
    if (exWrites && (exDest != '0)) begin
      if ((usesRs && (exDest == rsId)) || (usesRt && (exDest == rtId))) begin
        branchHazard = 1'b1;
      end
    end
    if (memLoad && (rDestMem != '0)) begin
      if ((usesRs && (rDestMem == rsId)) || (usesRt && (rDestMem == rtId))) begin
        branchHazard = 1'b1;
      end
    end
  end

  assign hazard = loadUse || branchHazard;

  // Freeze PC and IF/ID, bubble into ID/EX
  assign stallPc   = hazard;
  assign stallId   = hazard;
  assign stallIdEx = hazard;

  stallsAgree: assert final ((stallPc == stallId) && (stallId == stallIdEx))
    else $error("hazardUnit: stall outputs disagree");

endmodule

//--- hdl/instructionDecode.sv
module instructionDecode import decodePkg::*; (
  input  logic                Clock,
  input  logic                rstN,
  input  logic [DataW-1:0]    instruction,
  input  logic [DataW-1:0]    pcPlusFour,
  input  logic [RegAddrW-1:0] rDestSelectedId,
  input  logic [DataW-1:0]    regWriteData,
  input  logic                regWrite,
  input  logic [RegAddrW-1:0] rtEx,
  input  logic [RegAddrW-1:0] rdEx,
  input  logic [RegAddrW-1:0] rDestSelectedMem,
  input  logic [5:0]          opcodeEx,
  input  logic [5:0]          opcodeMem,
  output logic                pcSel,
  output logic [DataW-1:0]    branchPc,
  output logic                regWriteOut,
  output logic                memToReg,
  output logic                rEnable,
  output logic                wEnable,
  output logic [1:0]          rWidth,
  output logic [1:0]          wWidth,
  output logic                regDst,
  output logic [1:0]          aluSrc1,
  output logic                aluSrc0,
  output logic [DataW-1:0]    regData1,
  output logic [DataW-1:0]    regData2,
  output logic [DataW-1:0]    imm32,
  output logic                stallPc,
  output logic                stallId,
  output logic                stallIdEx
);

  opcodeT              opcode;
  functT               funct;
  logic [RegAddrW-1:0] rsField;
  logic [RegAddrW-1:0] rtField;
  ctrlT                ctrl;
  logic                rsSel;
  logic                rtSel;

  regReadIf rdBus ();

  //////////////////////////////////////////////////
  // Field split
  //////////////////////////////////////////////////

  assign opcode  = opcodeT'(instruction[31:26]);
  assign funct   = functT'(instruction[5:0]);
  assign rsField = instruction[25:21];
  assign rtField = instruction[20:16];

  mainControl u_mainControl (
    .opcode (opcode),
    .funct  (funct),
    .ctrl   (ctrl),
    .rsSel  (rsSel),
    .rtSel  (rtSel)
  );

  // jal reads the link register, j and jal read zero on rt
  assign rdBus.rsAddr = rsSel ? LinkReg : rsField;
  assign rdBus.rtAddr = rtSel ? '0 : rtField;

  registerFile u_registerFile (
    .Clock (Clock),
    .rstN  (rstN),
    .rd    (rdBus),
    .wAddr (rDestSelectedId),
    .wData (regWriteData),
    .wEn   (regWrite)
  );

  branchResolve u_branchResolve (
    .instr      (instruction),
    .pcPlusFour (pcPlusFour),
    .rsData     (rdBus.rsData),
    .rtData     (rdBus.rtData),
    .imm32      (imm32),
    .pcSel      (pcSel),
    .branchPc   (branchPc)
  );

  // Raw rs/rt fields are what the ID instruction depends on
  hazardUnit u_hazardUnit (
    .opcodeId  (opcode),
    .functId   (funct),
    .rsId      (rsField),
    .rtId      (rtField),
    .opcodeEx  (opcodeT'(opcodeEx)),
    .rtEx      (rtEx),
    .rdEx      (rdEx),
    .opcodeMem (opcodeT'(opcodeMem)),
    .rDestMem  (rDestSelectedMem),
    .stallPc   (stallPc),
    .stallId   (stallId),
    .stallIdEx (stallIdEx)
  );

  //////////////////////////////////////////////////
  // Control bundle onto plain ports
  //////////////////////////////////////////////////

  assign regDst      = ctrl.regDst;
  assign aluSrc0     = ctrl.aluSrc0;
  assign aluSrc1     = ctrl.aluSrc1;
  assign rEnable     = ctrl.rEnable;
  assign wEnable     = ctrl.wEnable;
  assign rWidth      = ctrl.rWidth;
  assign wWidth      = ctrl.wWidth;
  assign memToReg    = ctrl.memToReg;
  assign regWriteOut = ctrl.regWrite;

  // Operands for ID/EX
  assign regData1 = rdBus.rsData;
  assign regData2 = rdBus.rtData;

endmodule

//--- hdl/mainControl.sv
module mainControl import decodePkg::*; (
  input  opcodeT opcode,
  input  functT  funct,
  output ctrlT   ctrl,
  output logic   rsSel,
  output logic   rtSel
);

  //////////////////////////////////////////////////
  // Main decode table
  //////////////////////////////////////////////////

  always_comb begin
    // Quiet bundle unless a row below claims the opcode
    ctrl          = '0;
    ctrl.aluSrc1  = AluSrcReg;
    ctrl.rWidth   = WidthByte;
    ctrl.wWidth   = WidthByte;

    case (opcode)
      RType: begin
        // Only ALU functions write back while jr and the sll nop stay quiet
        if (funct inside {Add, Sub, And, Or, Slt}) begin
          ctrl.regDst   = 1'b1;
          ctrl.regWrite = 1'b1;
        end
      end

      Addi: begin
        ctrl.aluSrc1  = AluSrcImm;
        ctrl.regWrite = 1'b1;
      end

      Lw, Lb: begin
        ctrl.aluSrc1  = AluSrcImm;
        ctrl.regWrite = 1'b1;
        ctrl.rEnable  = 1'b1;
        ctrl.memToReg = 1'b1;
        // Word or sign-extended byte read
        ctrl.rWidth   = (opcode == Lw) ? WidthWord : WidthByte;
      end

      Sw, Sb: begin
        ctrl.wEnable = 1'b1;
        ctrl.wWidth  = (opcode == Sw) ? WidthWord : WidthByte;
      end

      Jal: begin
        // PC+4 goes through the ALU into the link register
        ctrl.aluSrc1  = AluSrcLink;
        ctrl.regWrite = 1'b1;
      end

      // beq, bne and j resolve in ID and write nothing
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Register read selects
  //////////////////////////////////////////////////

  // High picks LinkReg instead of the rs field
  assign rsSel = (opcode == Jal);

  // High picks register zero instead of the rt field
  assign rtSel = (opcode == J) || (opcode == Jal);

  // A memory slot is either read or written, never both
  noReadAndWrite: assert final (!(ctrl.rEnable && ctrl.wEnable))
    else $error("mainControl: rEnable and wEnable both high, opcode %h", opcode);

endmodule

//--- hdl/registerFile.sv
module registerFile import decodePkg::*; (
  input  logic                Clock,
  input  logic                rstN,
  regReadIf.responder         rd,
  input  logic [RegAddrW-1:0] wAddr,
  input  logic [DataW-1:0]    wData,
  input  logic                wEn
);

  // Register zero has no storage
  logic [DataW-1:0] regs [1:(1 << RegAddrW) - 1];

  //////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////

  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < (1 << RegAddrW); i++) begin
        regs[i] <= '0;
      end
    end else if (wEn && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // No bypass, a write shows up from the next cycle on
  assign rd.rsData = (rd.rsAddr == '0) ? '0 : regs[rd.rsAddr];
  assign rd.rtData = (rd.rtAddr == '0) ? '0 : regs[rd.rtAddr];

  // WB must present a clean address whenever it writes
  wAddrKnown: assert property (
    @(posedge Clock) disable iff (!rstN)
    wEn |-> !$isunknown(wAddr)
  ) else $error("registerFile: write with unknown address %b", wAddr);

endmodule
